//--- Bender.yml
package:
  name: ptw_sv39

sources:
  - ptw_pkg.sv
  - ptw_pte_check.sv
  - ptw_ptr_gen.sv
  - ptw_walk_ctrl.sv
  - ptw_sv39.sv
  - target: test
    files:
      - tb_ptw_sv39.sv

//--- ptw_pkg.sv
// Shared widths, page table entry layout, walk level and state types, cause and response codes
package ptw_pkg;

    // Address widths for Sv39
    localparam int unsigned PLEN   = 56;
    localparam int unsigned VLEN   = 39;

    // Page number widths
    localparam int unsigned PPNW   = 44;
    localparam int unsigned VPNW   = 27;

    // Process context ID carried into the IOTLB
    localparam int unsigned PSCIDW = 20;

    // Width of the fault cause reported to the IOMMU
    localparam int unsigned CAUSE_LEN = 11;

    // Position of the global flag inside an entry
    localparam int unsigned PTE_G_BIT = 5;

    // Sv39 page table entry, upper bits first
    typedef struct packed {
        // Reserved for extensions, must be zero
        logic [9:0]      reserved;
        // Physical page number
        logic [PPNW-1:0] ppn;
        // Left to software
        logic [1:0]      rsw;
        // Dirty
        logic            d;
        // Accessed
        logic            a;
        // Global mapping
        logic            g;
        // User accessible
        logic            u;
        // Execute permission
        logic            x;
        // Write permission
        logic            w;
        // Read permission
        logic            r;
        // Valid
        logic            v;
    } pte_t;

    // Walk level, LVL1 maps 1G, LVL2 maps 2M, LVL3 maps 4K
    typedef enum logic [1:0] {
        LVL1,
        LVL2,
        LVL3
    } level_e;

    // Walk controller states
    typedef enum logic [1:0] {
        IDLE,
        MEM_ACCESS,
        PROC_PTE,
        ERROR
    } walk_state_e;

    // Fault causes
    localparam logic [CAUSE_LEN-1:0] LOAD_PAGE_FAULT    = 11'd13;
    localparam logic [CAUSE_LEN-1:0] STORE_PAGE_FAULT   = 11'd15;
    // Bus error while reading an entry
    localparam logic [CAUSE_LEN-1:0] PT_DATA_CORRUPTION = 11'd274;

    // Read response code for a good transfer
    localparam logic [1:0] RESP_OKAY = 2'b00;

endpackage

//--- ptw_pte_check.sv
// Leaf detection and page-fault rules for one fetched page table entry
`timescale 1ns/1ps

module ptw_pte_check import ptw_pkg::*; (
    // Entry as returned on the read data bus
    input  pte_t   pte_i,
    // Level at which the entry was fetched
    input  level_e level_i,
    // Access type of the translation that started the walk
    input  logic   is_store_i,
    output logic   leaf_o,
    output logic   fault_o
);

    logic invalid;
    logic reserved_set;
    logic misaligned;
    logic leaf_fault;
    logic ptr_fault;

    // Any of R or X marks a leaf, otherwise the entry points to the next table
    assign leaf_o = pte_i.r | pte_i.x;

    // Not valid, or write-only which is a reserved encoding
    assign invalid = ~pte_i.v | (pte_i.w & ~pte_i.r);

    // Upper ten bits are reserved for standard use
    assign reserved_set = |pte_i.reserved;

    // Superpage ppn must be aligned to its size
    always_comb begin
        misaligned = 1'b0;
        case (level_i)
            // 1G page, low two ppn segments must be zero
            LVL1: misaligned = |pte_i.ppn[17:0];
            // 2M page, low ppn segment must be zero
            LVL2: misaligned = |pte_i.ppn[8:0];
            default: misaligned = 1'b0;
        endcase
    end

    // Leaf rules
    // A clear means the page was never accessed
    // Store to a page that is not dirty also faults
    // Execute-only leaves are not readable by the device
    assign leaf_fault = misaligned
                      | ~pte_i.a
                      | ~pte_i.r
                      | (is_store_i & ~pte_i.d);

    // Pointer rules
    // D, A and U are reserved in non-leaf entries
    // A pointer found at the last level has nowhere to go
    assign ptr_fault = pte_i.a
                     | pte_i.d
                     | pte_i.u
                     | (level_i == LVL3);

    // Combine the common checks with the kind-specific ones
    always_comb begin
        fault_o = invalid | reserved_set;
        if (leaf_o) begin
            fault_o = fault_o | leaf_fault;
        end else begin
            fault_o = fault_o | ptr_fault;
        end
    end

endmodule

//--- ptw_ptr_gen.sv
// Pointer register with the physical address of the next page table entry to fetch
`timescale 1ns/1ps

module ptw_ptr_gen import ptw_pkg::*; (
    input  logic            clk_i,
    input  logic            rst_ni,
    // Start of a walk, load the first-level pointer
    input  logic            load_root_i,
    // Valid non-leaf entry accepted, step down one table
    input  logic            advance_i,
    // Root table from satp
    input  logic [PPNW-1:0] satp_ppn_i,
    // Address under translation
    input  logic [VLEN-1:0] iova_i,
    // ppn of the non-leaf entry just accepted
    input  logic [PPNW-1:0] pte_ppn_i,
    // Level of that entry
    input  level_e          level_i,
    // Address of the next 8-byte entry
    output logic [PLEN-1:0] ptr_o
);

    logic [PLEN-1:0] ptr_q;
    logic [PLEN-1:0] ptr_n;
    logic [8:0]      root_vpn;
    logic [8:0]      next_vpn;

    // VPN[2] indexes the root table
    assign root_vpn = iova_i[38:30];

    // Index into the table one level below the current one
    always_comb begin
        case (level_i)
            // Next table is the 2M level
            LVL1: next_vpn = iova_i[29:21];
            // Next table is the 4K level
            LVL2: next_vpn = iova_i[20:12];
            // No table below LVL3, the checker faults such entries
            default: next_vpn = iova_i[20:12];
        endcase
    end

    // Root load wins, a walk never starts while stepping
    always_comb begin
        ptr_n = ptr_q;
        if (load_root_i) begin
            ptr_n = {satp_ppn_i, root_vpn, 3'b000};
        end else if (advance_i) begin
            ptr_n = {pte_ppn_i, next_vpn, 3'b000};
        end
    end

    // Pointer updates one cycle after the strobe
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            ptr_q <= '0;
        end else begin
            ptr_q <= ptr_n;
        end
    end

    // Held steady while the read request waits
    assign ptr_o = ptr_q;

endmodule

//--- ptw_sv39.sv
// Sv39 page table walker top with controller, entry checker and pointer generator
`timescale 1ns/1ps

module ptw_sv39 import ptw_pkg::*; (
    input  logic                 clk_i,
    input  logic                 rst_ni,
    // Walk request
    input  logic                 init_ptw_i,
    input  logic                 is_store_i,
    input  logic [VLEN-1:0]      iova_i,
    input  logic [PSCIDW-1:0]    pscid_i,
    // Root table
    input  logic [PPNW-1:0]      satp_ppn_i,
    // Memory read channel
    output logic                 ar_valid_o,
    output logic [PLEN-1:0]      ar_addr_o,
    input  logic                 ar_ready_i,
    input  logic                 r_valid_i,
    input  logic [63:0]          r_data_i,
    input  logic [1:0]           r_resp_i,
    output logic                 r_ready_o,
    // Status and results
    output logic                 ptw_active_o,
    output logic                 update_o,
    output logic [VPNW-1:0]      up_vpn_o,
    output logic [PSCIDW-1:0]    up_pscid_o,
    output pte_t                 up_pte_o,
    output logic                 up_is_2m_o,
    output logic                 up_is_1g_o,
    output logic                 ptw_error_o,
    output logic [CAUSE_LEN-1:0] cause_code_o
);

    pte_t            pte;
    level_e          level;
    logic            is_store;
    logic [VLEN-1:0] iova;
    logic            leaf;
    logic            fault;
    logic            load_root;
    logic            advance;

    ptw_walk_ctrl i_walk_ctrl (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .init_ptw_i   (init_ptw_i),
        .is_store_i   (is_store_i),
        .iova_i       (iova_i),
        .pscid_i      (pscid_i),
        .ar_ready_i   (ar_ready_i),
        .r_valid_i    (r_valid_i),
        .r_data_i     (r_data_i),
        .r_resp_i     (r_resp_i),
        .leaf_i       (leaf),
        .fault_i      (fault),
        .ar_valid_o   (ar_valid_o),
        .r_ready_o    (r_ready_o),
        .ptw_active_o (ptw_active_o),
        .pte_o        (pte),
        .level_o      (level),
        .is_store_o   (is_store),
        .iova_o       (iova),
        .load_root_o  (load_root),
        .advance_o    (advance),
        .update_o     (update_o),
        .up_vpn_o     (up_vpn_o),
        .up_pscid_o   (up_pscid_o),
        .up_pte_o     (up_pte_o),
        .up_is_2m_o   (up_is_2m_o),
        .up_is_1g_o   (up_is_1g_o),
        .ptw_error_o  (ptw_error_o),
        .cause_code_o (cause_code_o)
    );

    // Judges the entry on the data bus in the same cycle
    ptw_pte_check i_pte_check (
        .pte_i      (pte),
        .level_i    (level),
        .is_store_i (is_store),
        .leaf_o     (leaf),
        .fault_o    (fault)
    );

    // Its pointer is the read address
    ptw_ptr_gen i_ptr_gen (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .load_root_i (load_root),
        .advance_i   (advance),
        .satp_ppn_i  (satp_ppn_i),
        .iova_i      (iova),
        .pte_ppn_i   (pte.ppn),
        .level_i     (level),
        .ptr_o       (ar_addr_o)
    );

endmodule

//--- ptw_walk_ctrl.sv
// Walk FSM with level tracking, request latches, IOTLB update and error reporting
`timescale 1ns/1ps

module ptw_walk_ctrl import ptw_pkg::*; (
    input  logic                 clk_i,
    input  logic                 rst_ni,
    // Start request and its attributes
    input  logic                 init_ptw_i,
    input  logic                 is_store_i,
    input  logic [VLEN-1:0]      iova_i,
    input  logic [PSCIDW-1:0]    pscid_i,
    // Memory read channel
    input  logic                 ar_ready_i,
    input  logic                 r_valid_i,
    input  logic [63:0]          r_data_i,
    input  logic [1:0]           r_resp_i,
    // Checker results for the current entry
    input  logic                 leaf_i,
    input  logic                 fault_i,
    output logic                 ar_valid_o,
    output logic                 r_ready_o,
    output logic                 ptw_active_o,
    // To checker and pointer generator
    output pte_t                 pte_o,
    output level_e               level_o,
    output logic                 is_store_o,
    output logic [VLEN-1:0]      iova_o,
    output logic                 load_root_o,
    output logic                 advance_o,
    // IOTLB update
    output logic                 update_o,
    output logic [VPNW-1:0]      up_vpn_o,
    output logic [PSCIDW-1:0]    up_pscid_o,
    output pte_t                 up_pte_o,
    output logic                 up_is_2m_o,
    output logic                 up_is_1g_o,
    // Error report
    output logic                 ptw_error_o,
    output logic [CAUSE_LEN-1:0] cause_code_o
);

    walk_state_e          state_q, state_n;
    level_e               level_q, level_n;
    logic                 init_q;
    logic                 start;
    logic                 global_q, global_n;
    logic [CAUSE_LEN-1:0] cause_q, cause_n;
    logic [VLEN-1:0]      iova_q;
    logic [PSCIDW-1:0]    pscid_q;
    logic                 is_store_q;
    logic                 r_xfer;

    // Read data seen as an entry
    assign pte_o = pte_t'(r_data_i);

    // Only a fresh rising edge starts a walk
    assign start = init_ptw_i & ~init_q;

    assign r_xfer = r_ready_o & r_valid_i;

    // Root pointer is built in the start cycle, before the latch holds the address
    assign iova_o     = (state_q == IDLE) ? iova_i : iova_q;
    assign is_store_o = is_store_q;
    assign level_o    = level_q;

    // Bus handshakes
    assign ar_valid_o   = (state_q == MEM_ACCESS);
    assign r_ready_o    = (state_q == PROC_PTE) & r_valid_i;
    assign ptw_active_o = (state_q != IDLE);

    // Update fields, qualified by update_o
    assign up_vpn_o   = iova_q[38:12];
    assign up_pscid_o = pscid_q;
    assign up_is_1g_o = (level_q == LVL1);
    assign up_is_2m_o = (level_q == LVL2);
    // Global bit inherited from any pointer on the way down
    assign up_pte_o   = pte_t'(r_data_i | (64'(global_q) << PTE_G_BIT));

    // Error is reported one cycle after the faulting transfer
    assign ptw_error_o  = (state_q == ERROR);
    assign cause_code_o = ptw_error_o ? cause_q : '0;

    always_comb begin
        state_n     = state_q;
        level_n     = level_q;
        global_n    = global_q;
        cause_n     = cause_q;
        load_root_o = 1'b0;
        advance_o   = 1'b0;
        update_o    = 1'b0;

        case (state_q)
            IDLE: begin
                if (start) begin
                    state_n     = MEM_ACCESS;
                    level_n     = LVL1;
                    global_n    = 1'b0;
                    load_root_o = 1'b1;
                end
            end

            // Request stays up until the bus takes it
            MEM_ACCESS: begin
                if (ar_ready_i) begin
                    state_n = PROC_PTE;
                end
            end

            PROC_PTE: begin
                if (r_xfer) begin
                    if (r_resp_i != RESP_OKAY) begin
                        // Bus error outranks whatever the data looks like
                        cause_n = PT_DATA_CORRUPTION;
                        state_n = ERROR;
                    end else if (fault_i) begin
                        cause_n = is_store_q ? STORE_PAGE_FAULT : LOAD_PAGE_FAULT;
                        state_n = ERROR;
                    end else if (leaf_i) begin
                        // Translation found, IOTLB takes it in this cycle
                        update_o = 1'b1;
                        state_n  = IDLE;
                    end else begin
                        // Valid pointer, fetch from the next table
                        advance_o = 1'b1;
                        global_n  = global_q | pte_o.g;
                        level_n   = (level_q == LVL1) ? LVL2 : LVL3;
                        state_n   = MEM_ACCESS;
                    end
                end
            end

            ERROR: begin
                state_n = IDLE;
            end

            default: begin
                state_n = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q  <= IDLE;
            level_q  <= LVL1;
            init_q   <= 1'b0;
            global_q <= 1'b0;
            cause_q  <= '0;
        end else begin
            state_q  <= state_n;
            level_q  <= level_n;
            init_q   <= init_ptw_i;
            global_q <= global_n;
            cause_q  <= cause_n;
        end
    end

    // Request attributes, sampled once per walk
    always_ff @(posedge clk_i) begin
        if (state_q == IDLE && start) begin
            iova_q     <= iova_i;
            pscid_q    <= pscid_i;
            is_store_q <= is_store_i;
        end
    end

endmodule

//--- tb.f
ptw_pkg.sv
ptw_pte_check.sv
ptw_ptr_gen.sv
ptw_walk_ctrl.sv
ptw_sv39.sv
tb_ptw_sv39.sv

//--- tb_ptw_sv39.sv
// Testbench for the Sv39 walker with case table, memory responder, compare tasks and watchdog
`timescale 1ns/1ps

module tb_ptw_sv39 import ptw_pkg::*; ();

    localparam int unsigned NUM_CASES = 8;
    // Three fetches of at most ten cycles each plus reset and slack
    localparam int unsigned TIMEOUT_CYCLES = NUM_CASES * 3 * 10 + 100;

    // Entry flags as {d, a, g, u, x, w, r, v}
    localparam logic [7:0] F_PTR   = 8'h01;
    localparam logic [7:0] F_PTR_G = 8'h21;
    localparam logic [7:0] F_LEAF  = 8'hCF;
    localparam logic [7:0] F_CLEAN = 8'h4F;
    localparam logic [7:0] F_INVAL = 8'h00;

    // One walk with its memory image and expected outcome
    typedef struct packed {
        logic [VLEN-1:0]      iova;
        logic [PPNW-1:0]      satp;
        logic [PSCIDW-1:0]    pscid;
        logic                 is_store;
        logic [1:0]           nfetch;
        logic [2:0][PLEN-1:0] addr;
        logic [2:0][63:0]     data;
        // Bus error on the last fetch
        logic                 berr;
        logic                 exp_update;
        pte_t                 exp_pte;
        logic                 exp_1g;
        logic                 exp_2m;
        logic [CAUSE_LEN-1:0] exp_cause;
    } case_t;

    case_t cases [NUM_CASES];
    case_t cur;
    int    seed;

    logic                 clk_i;
    logic                 rst_ni;
    logic                 init_ptw_i;
    logic                 is_store_i;
    logic [VLEN-1:0]      iova_i;
    logic [PSCIDW-1:0]    pscid_i;
    logic [PPNW-1:0]      satp_ppn_i;
    logic                 ar_valid_o;
    logic [PLEN-1:0]      ar_addr_o;
    logic                 ar_ready_i;
    logic                 r_valid_i;
    logic [63:0]          r_data_i;
    logic [1:0]           r_resp_i;
    logic                 r_ready_o;
    logic                 ptw_active_o;
    logic                 update_o;
    logic [VPNW-1:0]      up_vpn_o;
    logic [PSCIDW-1:0]    up_pscid_o;
    pte_t                 up_pte_o;
    logic                 up_is_2m_o;
    logic                 up_is_1g_o;
    logic                 ptw_error_o;
    logic [CAUSE_LEN-1:0] cause_code_o;

    ptw_sv39 i_ptw_sv39 (.*);

    always #2 clk_i = ~clk_i;

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("Simulation failed");
        $fatal(1, "stopped at first mismatch");
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp)
            report_failure($sformatf("error %s: got 0x%h, expected 0x%h", name, got, exp));
    endtask

    task automatic check_addr(input string name, input logic [PLEN-1:0] got,
                              input logic [PLEN-1:0] exp);
        if (got !== exp)
            report_failure($sformatf("error %s: got 0x%h, expected 0x%h", name, got, exp));
    endtask

    task automatic check_id(input string name, input logic [PSCIDW-1:0] got,
                            input logic [PSCIDW-1:0] exp);
        if (got !== exp)
            report_failure($sformatf("error %s: got 0x%h, expected 0x%h", name, got, exp));
    endtask

    task automatic check_pte(input string name, input pte_t got, input pte_t exp);
        if (got !== exp)
            report_failure($sformatf("error %s: got 0x%h, expected 0x%h", name, got, exp));
    endtask

    task automatic check_cause(input string name, input logic [CAUSE_LEN-1:0] got,
                               input logic [CAUSE_LEN-1:0] exp);
        if (got !== exp)
            report_failure($sformatf("error %s: got 0x%h, expected 0x%h", name, got, exp));
    endtask

    function automatic pte_t make_pte(input logic [PPNW-1:0] ppn, input logic [7:0] flags);
        return pte_t'({10'b0, ppn, 2'b00, flags});
    endfunction

    // Entry addresses follow the Sv39 indexing from the root down
    task automatic add_walk(input int idx, input logic [VLEN-1:0] iova,
                            input logic [PPNW-1:0] satp, input logic store,
                            input int n, input logic berr,
                            input pte_t e0, input pte_t e1, input pte_t e2,
                            input logic upd, input logic is_1g, input logic is_2m,
                            input logic [CAUSE_LEN-1:0] cause, input pte_t exp_pte);
        cases[idx].iova       = iova;
        cases[idx].satp       = satp;
        cases[idx].pscid      = PSCIDW'(20'h1A0 + idx);
        cases[idx].is_store   = store;
        cases[idx].nfetch     = 2'(n);
        cases[idx].addr[0]    = {satp, iova[38:30], 3'b000};
        cases[idx].addr[1]    = {e0.ppn, iova[29:21], 3'b000};
        cases[idx].addr[2]    = {e1.ppn, iova[20:12], 3'b000};
        cases[idx].data[0]    = e0;
        cases[idx].data[1]    = e1;
        cases[idx].data[2]    = e2;
        cases[idx].berr       = berr;
        cases[idx].exp_update = upd;
        cases[idx].exp_1g     = is_1g;
        cases[idx].exp_2m     = is_2m;
        cases[idx].exp_cause  = cause;
        cases[idx].exp_pte    = exp_pte;
    endtask

    // One entry fetch starting at a falling edge with the request expected up
    task automatic fetch_entry(input int k);
        logic [PLEN-1:0] addr;
        logic [63:0]     data;
        int              gap;
        int              j;
        check_bit("ar_valid_o", ar_valid_o, 1'b1);
        check_addr("ar_addr_o", ar_addr_o, cur.addr[k]);
        addr = ar_addr_o;
        // Request must stay put while ar_ready_i is held off
        gap = $random(seed) & 3;
        repeat (gap) begin
            @(posedge clk_i);
            @(negedge clk_i);
            check_bit("ar_valid_o", ar_valid_o, 1'b1);
            check_addr("ar_addr_o", ar_addr_o, addr);
        end
        @(posedge clk_i);
        #1 ar_ready_i = 1'b1;
        @(posedge clk_i);
        #1 ar_ready_i = 1'b0;
        // Memory lookup over this walk's entries
        data = '0;
        for (j = 0; j < cur.nfetch; j++) begin
            if (cur.addr[j] == addr) begin
                data = cur.data[j];
            end
        end
        gap = $random(seed) & 3;
        repeat (gap) begin
            @(posedge clk_i);
            #1;
        end
        r_valid_i = 1'b1;
        r_data_i  = data;
        r_resp_i  = (cur.berr && k == cur.nfetch - 1) ? 2'b10 : RESP_OKAY;
        @(negedge clk_i);
        check_bit("r_ready_o", r_ready_o, 1'b1);
        if (k == cur.nfetch - 1) begin
            // Update pulse comes with the last data transfer
            check_bit("update_o", update_o, cur.exp_update);
            if (cur.exp_update) begin
                check_pte("up_pte_o", up_pte_o, cur.exp_pte);
                check_addr("up_vpn_o", PLEN'(up_vpn_o), PLEN'(cur.iova[38:12]));
                check_id("up_pscid_o", up_pscid_o, cur.pscid);
                check_bit("up_is_1g_o", up_is_1g_o, cur.exp_1g);
                check_bit("up_is_2m_o", up_is_2m_o, cur.exp_2m);
            end
        end else begin
            check_bit("update_o", update_o, 1'b0);
        end
        @(posedge clk_i);
        #1;
        r_valid_i = 1'b0;
        r_resp_i  = RESP_OKAY;
        @(negedge clk_i);
    endtask

    task automatic run_case(input int idx);
        int k;
        cur = cases[idx];
        @(posedge clk_i);
        #1;
        iova_i     = cur.iova;
        satp_ppn_i = cur.satp;
        pscid_i    = cur.pscid;
        is_store_i = cur.is_store;
        init_ptw_i = 1'b1;
        @(negedge clk_i);
        check_bit("ar_valid_o", ar_valid_o, 1'b0);
        // Request one cycle after the start edge
        @(negedge clk_i);
        check_bit("ptw_active_o", ptw_active_o, 1'b1);
        for (k = 0; k < cur.nfetch; k++) begin
            fetch_entry(k);
        end
        if (cur.exp_update) begin
            check_bit("ptw_active_o", ptw_active_o, 1'b0);
            check_bit("ptw_error_o", ptw_error_o, 1'b0);
        end else begin
            // Error one cycle after the faulting transfer
            check_bit("ptw_error_o", ptw_error_o, 1'b1);
            check_cause("cause_code_o", cause_code_o, cur.exp_cause);
            check_bit("update_o", update_o, 1'b0);
            @(negedge clk_i);
            check_bit("ptw_error_o", ptw_error_o, 1'b0);
            check_bit("ptw_active_o", ptw_active_o, 1'b0);
        end
        // No second walk while the start input stays high
        repeat (3) begin
            @(negedge clk_i);
            check_bit("ar_valid_o", ar_valid_o, 1'b0);
            check_bit("ptw_active_o", ptw_active_o, 1'b0);
        end
        @(posedge clk_i);
        #1 init_ptw_i = 1'b0;
        @(posedge clk_i);
    endtask

    initial begin
        repeat (TIMEOUT_CYCLES) @(posedge clk_i);
        $display("Timeout: the walks did not finish in the expected number of cycles");
        $display("Simulation failed");
        $fatal(1, "watchdog expired");
    end

    initial begin
        seed       = 7358;
        clk_i      = 1'b0;
        rst_ni     = 1'b0;
        init_ptw_i = 1'b0;
        is_store_i = 1'b0;
        iova_i     = '0;
        pscid_i    = '0;
        satp_ppn_i = '0;
        ar_ready_i = 1'b0;
        r_valid_i  = 1'b0;
        r_data_i   = '0;
        r_resp_i   = RESP_OKAY;

        // 4K walk through two pointers
        add_walk(0, 39'h12_3456_7000, 44'h8_0000, 1'b0, 3, 1'b0,
                 make_pte(44'h8_1000, F_PTR), make_pte(44'h8_2000, F_PTR),
                 make_pte(44'h9_1234, F_LEAF), 1'b1, 1'b0, 1'b0, '0,
                 make_pte(44'h9_1234, F_LEAF));
        // 1G leaf at the root for a store to a dirty page
        add_walk(1, 39'h4A_8765_4321, 44'h8_4000, 1'b1, 1, 1'b0,
                 make_pte(44'h4_0000, F_LEAF), '0, '0, 1'b1, 1'b1, 1'b0, '0,
                 make_pte(44'h4_0000, F_LEAF));
        // 2M leaf below a global pointer
        add_walk(2, 39'h23_55A0_0000, 44'h8_5000, 1'b0, 2, 1'b0,
                 make_pte(44'h8_6000, F_PTR_G), make_pte(44'h8_3200, F_LEAF), '0,
                 1'b1, 1'b0, 1'b1, '0, make_pte(44'h8_3200, 8'hEF));
        // Invalid root entry
        add_walk(3, 39'h01_0203_4000, 44'h8_7000, 1'b0, 1, 1'b0,
                 make_pte(44'h8_8000, F_INVAL), '0, '0, 1'b0, 1'b0, 1'b0,
                 LOAD_PAGE_FAULT, '0);
        // Misaligned 2M superpage
        add_walk(4, 39'h33_1111_2000, 44'h8_9000, 1'b1, 2, 1'b0,
                 make_pte(44'h8_A000, F_PTR), make_pte(44'h8_3201, F_LEAF), '0,
                 1'b0, 1'b0, 1'b0, STORE_PAGE_FAULT, '0);
        // Store to a clean 4K page
        add_walk(5, 39'h5C_0F0F_0000, 44'h8_B000, 1'b1, 3, 1'b0,
                 make_pte(44'h8_C000, F_PTR), make_pte(44'h8_D000, F_PTR),
                 make_pte(44'h9_5555, F_CLEAN), 1'b0, 1'b0, 1'b0, STORE_PAGE_FAULT, '0);
        // Pointer found at the last level
        add_walk(6, 39'h0F_ABCD_E000, 44'h8_E000, 1'b0, 3, 1'b0,
                 make_pte(44'h8_F000, F_PTR), make_pte(44'h9_0000, F_PTR),
                 make_pte(44'h9_1000, F_PTR), 1'b0, 1'b0, 1'b0, LOAD_PAGE_FAULT, '0);
        // Bus error on a good-looking 2M leaf
        add_walk(7, 39'h66_7777_8000, 44'h9_2000, 1'b0, 2, 1'b1,
                 make_pte(44'h9_3000, F_PTR), make_pte(44'h9_4000, F_LEAF), '0,
                 1'b0, 1'b0, 1'b0, PT_DATA_CORRUPTION, '0);

        repeat (8) @(posedge clk_i);
        #1 rst_ni = 1'b1;
        @(negedge clk_i);
        check_bit("ar_valid_o", ar_valid_o, 1'b0);
        check_bit("r_ready_o", r_ready_o, 1'b0);
        check_bit("update_o", update_o, 1'b0);
        check_bit("ptw_error_o", ptw_error_o, 1'b0);
        check_bit("ptw_active_o", ptw_active_o, 1'b0);

        for (int i = 0; i < NUM_CASES; i++) begin
            run_case(i);
        end

        $display("Simulation completed successfully");
        $finish;
    end

endmodule
